//--- files.f
+incdir+rtl
rtl/cache_bank_pkg.sv
rtl/bank_queue.sv
rtl/bank_tag_data.sv
rtl/bank_miss_resrv.sv
rtl/cache_bank.sv
tests/cache_bank_tb.sv

//--- Makefile
SIM        = verilator
TOP        = cache_bank_tb
FILELIST   = files.f
SIM_FLAGS  = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing -Wall
OBJ_DIR    = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only when the run prints the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- tests/cache_bank_tb.sv
`timescale 1ns/1ns
`include "cache_bank_settings.svh"

module cache_bank_tb;
    import cache_bank_pkg::*;

    localparam int NUM_TIDS   = 2 ** `BANK_TID_BITS;
    localparam int RAND_OPS   = 2000;
    localparam int RAND_LINES = 48;
    // About four times the expected length of all tests
    localparam int CYCLE_LIMIT = 4000 + RAND_OPS * 32;

    logic  clk;
    logic  reset;
    logic  core_req_valid;
    logic  core_req_write;
    addr_t core_req_addr;
    word_t core_req_data;
    tid_t  core_req_tid;
    logic  core_req_full;
    logic  core_rsp_valid;
    tid_t  core_rsp_tid;
    word_t core_rsp_data;
    addr_t core_rsp_addr;
    logic  core_rsp_pop = 1'b0;
    logic  dram_fill_req_valid;
    addr_t dram_fill_req_addr;
    logic  dram_fill_req_full;
    logic  dram_fill_rsp_valid = 1'b0;
    addr_t dram_fill_rsp_addr = '0;
    line_t dram_fill_rsp_data = '0;
    logic  dram_fill_rsp_ready;
    logic  dram_wb_req_valid;
    addr_t dram_wb_req_addr;
    line_t dram_wb_req_data;
    logic  dram_wb_req_pop = 1'b0;

    // Sparse DRAM contents and reference memory
    word_t dram_mem [addr_t];
    word_t ref_mem [addr_t];
    addr_t fill_pend_addr [$];
    int    fill_pend_due [$];

    logic [NUM_TIDS-1:0] exp_valid;
    word_t               exp_data [NUM_TIDS];
    addr_t               exp_addr [NUM_TIDS];

    int          cycle = 0;
    int          errors;
    int          outstanding;
    int          reads_accepted;
    int          rsp_count;
    int          wb_seen;
    int          test_err_start;
    int          tests_passed;
    int          tests_failed;
    logic        pop_enable;
    int unsigned pop_pct;
    logic        wb_check_en;
    addr_t       wb_expect_addr;
    string       cur_test;

    cache_bank dut_i (
        .clk                 (clk),
        .reset               (reset),
        .core_req_valid      (core_req_valid),
        .core_req_write      (core_req_write),
        .core_req_addr       (core_req_addr),
        .core_req_data       (core_req_data),
        .core_req_tid        (core_req_tid),
        .core_req_full       (core_req_full),
        .core_rsp_valid      (core_rsp_valid),
        .core_rsp_tid        (core_rsp_tid),
        .core_rsp_data       (core_rsp_data),
        .core_rsp_addr       (core_rsp_addr),
        .core_rsp_pop        (core_rsp_pop),
        .dram_fill_req_valid (dram_fill_req_valid),
        .dram_fill_req_addr  (dram_fill_req_addr),
        .dram_fill_req_full  (dram_fill_req_full),
        .dram_fill_rsp_valid (dram_fill_rsp_valid),
        .dram_fill_rsp_addr  (dram_fill_rsp_addr),
        .dram_fill_rsp_data  (dram_fill_rsp_data),
        .dram_fill_rsp_ready (dram_fill_rsp_ready),
        .dram_wb_req_valid   (dram_wb_req_valid),
        .dram_wb_req_addr    (dram_wb_req_addr),
        .dram_wb_req_data    (dram_wb_req_data),
        .dram_wb_req_pop     (dram_wb_req_pop)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle >= CYCLE_LIMIT) begin
            $display("Run timed out after %0d cycles in %s", cycle, cur_test);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic addr_t word_addr(input addr_t addr);
        return {addr[`BANK_ADDR_BITS-1:2], 2'b00};
    endfunction

    // Untouched memory holds a pattern of its own address
    function automatic word_t pattern_word(input addr_t addr);
        return addr ^ 32'h5a5a_0000;
    endfunction

    function automatic word_t dram_word(input addr_t addr);
        if (dram_mem.exists(word_addr(addr)))
            return dram_mem[word_addr(addr)];
        return pattern_word(word_addr(addr));
    endfunction

    function automatic line_t dram_line(input addr_t line_addr);
        line_t line;
        for (int w = 0; w < `BANK_LINE_WORDS; w++)
            line[w] = dram_word(line_addr + addr_t'(w * 4));
        return line;
    endfunction

    function automatic word_t ref_word(input addr_t addr);
        if (ref_mem.exists(word_addr(addr)))
            return ref_mem[word_addr(addr)];
        return pattern_word(word_addr(addr));
    endfunction

    // Reference model, applied in acceptance order
    function automatic word_t model_access(input logic write, input addr_t addr,
                                           input word_t data);
        if (write)
            ref_mem[word_addr(addr)] = data;
        return ref_word(addr);
    endfunction

    function automatic logic find_free_tid(output tid_t tid);
        tid = '0;
        for (int i = 0; i < NUM_TIDS; i++) begin
            if (!exp_valid[i]) begin
                tid = tid_t'(i);
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // Three tags per index, all 16 indices
    function automatic addr_t collide_line(input int k);
        return 32'h0004_0000 + addr_t'((k % `BANK_NUM_LINES) * 16) +
               addr_t'((k / `BANK_NUM_LINES) * 32'h1000);
    endfunction

    // Called on a falling edge; returns on the next one
    task automatic issue_req(input logic write, input addr_t addr, input word_t data);
        tid_t  tid;
        logic  have_tid;
        word_t expected;
        tid = '0;
        have_tid = write ? 1'b1 : find_free_tid(tid);
        while (core_req_full || !have_tid) begin
            @(negedge clk);
            have_tid = write ? 1'b1 : find_free_tid(tid);
        end
        core_req_valid = 1'b1;
        core_req_write = write;
        core_req_addr  = addr;
        core_req_data  = data;
        core_req_tid   = tid;
        // Full is low until the next rising edge, so this one is accepted
        expected = model_access(write, addr, data);
        if (!write) begin
            exp_valid[tid] = 1'b1;
            exp_data[tid]  = expected;
            exp_addr[tid]  = addr;
            outstanding++;
            reads_accepted++;
        end
        @(negedge clk);
        core_req_valid = 1'b0;
    endtask

    task automatic check_response(input tid_t tid, input word_t data, input addr_t addr);
        assert (exp_valid[tid]) else begin
            $display("%s: response with tid %0d has no outstanding read", cur_test, tid);
            errors++;
        end
        if (exp_valid[tid]) begin
            assert (data == exp_data[tid] && addr == exp_addr[tid]) else begin
                $display("Mismatch %s tid %0d: expected %h @ %h, actual %h @ %h", cur_test,
                         tid, exp_data[tid], exp_addr[tid], data, addr);
                errors++;
            end
            exp_valid[tid] = 1'b0;
            outstanding--;
        end
        rsp_count++;
    endtask

    task automatic store_writeback(input addr_t addr, input line_t line);
        if (wb_check_en) begin
            assert (addr == wb_expect_addr) else begin
                $display("Mismatch %s writeback address: expected %h, actual %h", cur_test,
                         wb_expect_addr, addr);
                errors++;
            end
            for (int w = 0; w < `BANK_LINE_WORDS; w++) begin
                assert (line[w] == ref_word(addr + addr_t'(w * 4))) else begin
                    $display("Mismatch %s writeback word %0d: expected %h, actual %h",
                             cur_test, w, ref_word(addr + addr_t'(w * 4)), line[w]);
                    errors++;
                end
            end
            wb_seen++;
        end
        for (int w = 0; w < `BANK_LINE_WORDS; w++)
            dram_mem[addr + addr_t'(w * 4)] = line[w];
    endtask

    // DRAM model
    always @(negedge clk) begin
        dram_wb_req_pop     = 1'b0;
        dram_fill_rsp_valid = 1'b0;
        if (!reset) begin
            if (dram_fill_req_valid) begin
                fill_pend_addr.push_back(dram_fill_req_addr);
                fill_pend_due.push_back(cycle + 2 + int'($urandom % 11));
            end
            if (dram_wb_req_valid && ($urandom % 2 == 0)) begin
                dram_wb_req_pop = 1'b1;
                store_writeback(dram_wb_req_addr, dram_wb_req_data);
            end else if (fill_pend_addr.size() > 0 && fill_pend_due[0] <= cycle &&
                         dram_fill_rsp_ready && !dram_wb_req_valid) begin
                // Fills wait for pending writebacks so they never read stale lines
                dram_fill_rsp_valid = 1'b1;
                dram_fill_rsp_addr  = fill_pend_addr.pop_front();
                dram_fill_rsp_data  = dram_line(dram_fill_rsp_addr);
                void'(fill_pend_due.pop_front());
            end
        end
    end

    // Response checker and core-side pop
    always @(negedge clk) begin
        core_rsp_pop = 1'b0;
        if (!reset && core_rsp_valid && pop_enable && ($urandom % 100 < pop_pct)) begin
            core_rsp_pop = 1'b1;
            check_response(core_rsp_tid, core_rsp_data, core_rsp_addr);
        end
    end

    task automatic wait_drain();
        while (outstanding != 0 || dram_wb_req_valid)
            @(negedge clk);
    endtask

    task automatic start_test(input string name);
        cur_test       = name;
        test_err_start = errors;
    endtask

    task automatic finish_test();
        assert (rsp_count == reads_accepted) else begin
            $display("Mismatch %s response count: expected %0d, actual %0d", cur_test,
                     reads_accepted, rsp_count);
            errors++;
        end
        if (errors == test_err_start) begin
            tests_passed++;
            $display("%s: passed", cur_test);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", cur_test, errors - test_err_start);
        end
    endtask

    task automatic run_miss_then_hit();
        start_test("read miss then hit");
        assert (!core_rsp_valid && !dram_fill_req_valid && !dram_wb_req_valid &&
                !core_req_full && dram_fill_rsp_ready) else begin
            $display("%s: outputs not idle after reset", cur_test);
            errors++;
        end
        for (int pass = 0; pass < 2; pass++) begin
            for (int i = 0; i < 16; i++)
                issue_req(1'b0, 32'h0000_2000 + addr_t'(i * 4), '0);
        end
        wait_drain();
        finish_test();
    endtask

    task automatic run_write_then_read();
        start_test("write then read");
        // Line 0x3050 is still missing, the others hit
        for (int i = 0; i < 4; i++) begin
            issue_req(1'b1, 32'h0000_2000 + addr_t'(i * 8), 32'hc0de_0000 + word_t'(i));
            issue_req(1'b1, 32'h0000_3050 + addr_t'(i * 4), 32'hbeef_0000 + word_t'(i));
        end
        for (int i = 0; i < 4; i++) begin
            issue_req(1'b0, 32'h0000_2000 + addr_t'(i * 8), '0);
            issue_req(1'b0, 32'h0000_3050 + addr_t'(i * 4), '0);
        end
        wait_drain();
        finish_test();
    endtask

    task automatic run_dirty_eviction();
        start_test("dirty eviction");
        for (int i = 0; i < 4; i++)
            issue_req(1'b1, 32'h0000_1040 + addr_t'(i * 4), 32'hd1e7_0000 + word_t'(i));
        issue_req(1'b0, 32'h0000_1044, '0);
        wait_drain();
        wb_seen        = 0;
        wb_expect_addr = 32'h0000_1040;
        wb_check_en    = 1'b1;
        // Same index, other tag
        issue_req(1'b0, 32'h0000_1148, '0);
        wait_drain();
        wb_check_en = 1'b0;
        assert (wb_seen == 1) else begin
            $display("%s: expected one writeback of the dirty line, saw %0d", cur_test,
                     wb_seen);
            errors++;
        end
        issue_req(1'b0, 32'h0000_1048, '0);
        wait_drain();
        finish_test();
    endtask

    task automatic run_back_pressure();
        tid_t ghost;
        int   k;
        start_test("back-pressure");
        pop_enable = 1'b0;
        k = 0;
        while (!core_req_full) begin
            issue_req(1'b0, 32'h0000_2000 + addr_t'((k % 16) * 4), '0);
            k++;
        end
        // Offered while full, never recorded
        void'(find_free_tid(ghost));
        core_req_valid = 1'b1;
        core_req_write = 1'b0;
        core_req_addr  = 32'h0000_2004;
        core_req_tid   = ghost;
        repeat (6) begin
            assert (core_req_full) else begin
                $display("%s: request queue dropped full with responses held", cur_test);
                errors++;
            end
            @(negedge clk);
        end
        core_req_valid = 1'b0;
        pop_enable     = 1'b1;
        wait_drain();
        finish_test();
    endtask

    task automatic run_random_traffic();
        addr_t addr;
        start_test("random traffic");
        pop_pct = 50;
        for (int n = 0; n < RAND_OPS; n++) begin
            addr = collide_line(int'($urandom % RAND_LINES)) + addr_t'(($urandom % 4) * 4);
            if ($urandom % 100 < 35)
                issue_req(1'b1, addr, $urandom);
            else
                issue_req(1'b0, addr, '0);
            if ($urandom % 8 == 0)
                @(negedge clk);
        end
        wait_drain();
        finish_test();
    endtask

    initial begin
        void'($urandom(32'hf9b736e1));
        clk                = 1'b0;
        reset              = 1'b1;
        core_req_valid     = 1'b0;
        core_req_write     = 1'b0;
        core_req_addr      = '0;
        core_req_data      = '0;
        core_req_tid       = '0;
        dram_fill_req_full = 1'b0;
        exp_valid          = '0;
        errors             = 0;
        outstanding        = 0;
        reads_accepted     = 0;
        rsp_count          = 0;
        wb_seen            = 0;
        tests_passed       = 0;
        tests_failed       = 0;
        pop_enable         = 1'b1;
        pop_pct            = 100;
        wb_check_en        = 1'b0;
        wb_expect_addr     = '0;
        cur_test           = "reset";
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        run_miss_then_hit();
        run_write_then_read();
        run_dirty_eviction();
        run_back_pressure();
        run_random_traffic();

        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- rtl/cache_bank.sv
`timescale 1ns/1ns
`include "cache_bank_settings.svh"

module cache_bank (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  core_req_valid,
    input  logic                  core_req_write,
    input  cache_bank_pkg::addr_t core_req_addr,
    input  cache_bank_pkg::word_t core_req_data,
    input  cache_bank_pkg::tid_t  core_req_tid,
    output logic                  core_req_full,
    output logic                  core_rsp_valid,
    output cache_bank_pkg::tid_t  core_rsp_tid,
    output cache_bank_pkg::word_t core_rsp_data,
    output cache_bank_pkg::addr_t core_rsp_addr,
    input  logic                  core_rsp_pop,
    output logic                  dram_fill_req_valid,
    output cache_bank_pkg::addr_t dram_fill_req_addr,
    input  logic                  dram_fill_req_full,
    input  logic                  dram_fill_rsp_valid,
    input  cache_bank_pkg::addr_t dram_fill_rsp_addr,
    input  cache_bank_pkg::line_t dram_fill_rsp_data,
    output logic                  dram_fill_rsp_ready,
    output logic                  dram_wb_req_valid,
    output cache_bank_pkg::addr_t dram_wb_req_addr,
    output cache_bank_pkg::line_t dram_wb_req_data,
    input  logic                  dram_wb_req_pop
);
    import cache_bank_pkg::*;

    core_req_t   reqq_head;
    logic        reqq_pop;
    logic        reqq_empty;
    core_rsp_t   rspq_in;
    core_rsp_t   rspq_head;
    logic        rspq_push;
    logic        rspq_empty;
    logic        rspq_full;
    line_msg_t   fillq_head;
    logic        fillq_pop;
    logic        fillq_empty;
    logic        fillq_full;
    line_msg_t   wbq_in;
    line_msg_t   wbq_head;
    logic        wbq_push;
    logic        wbq_empty;
    logic        wbq_full;

    miss_entry_t mrvq_head;
    logic        mrvq_head_ready;
    logic        mrvq_pop;
    logic        mrvq_full;
    logic        mrvq_stop;
    logic        miss_add;
    logic        line_pending;
    logic        fill_bcast;

    logic        stall;
    logic        s0_valid;
    core_req_t   s0_req;
    logic        st1_valid;
    logic        st1_fill;
    core_req_t   st1_req;
    line_t       st1_line;
    logic        st2_valid;
    logic        st2_fill;
    core_req_t   st2_req;
    word_t       st2_word;
    line_t       st2_line;
    logic [`BANK_TAG_BITS-1:0] st2_tag;
    logic        st2_hit;
    logic        st2_dirty;

    word_t       td_word;
    line_t       td_line;
    logic [`BANK_TAG_BITS-1:0] td_tag;
    logic        td_hit;
    logic        td_dirty;

    logic        read_hit2;
    logic        miss2;
    logic        need_fill2;
    logic        victim2;

    bank_queue #(.DEPTH(`BANK_REQQ_DEPTH), .payload_t(core_req_t)) request_queue (
        .clk(clk), .reset(reset),
        .push(core_req_valid && !core_req_full),
        .data_in('{core_req_write, core_req_addr, core_req_data, core_req_tid}),
        .pop(reqq_pop), .data_out(reqq_head), .empty(reqq_empty), .full(core_req_full)
    );

    bank_queue #(.DEPTH(`BANK_RSPQ_DEPTH), .payload_t(core_rsp_t)) response_queue (
        .clk(clk), .reset(reset), .push(rspq_push), .data_in(rspq_in),
        .pop(core_rsp_pop), .data_out(rspq_head), .empty(rspq_empty), .full(rspq_full)
    );

    bank_queue #(.DEPTH(`BANK_FILLQ_DEPTH), .payload_t(line_msg_t)) fill_queue (
        .clk(clk), .reset(reset), .push(dram_fill_rsp_valid),
        .data_in('{dram_fill_rsp_addr, dram_fill_rsp_data}),
        .pop(fillq_pop), .data_out(fillq_head), .empty(fillq_empty), .full(fillq_full)
    );

    bank_queue #(.DEPTH(`BANK_WBQ_DEPTH), .payload_t(line_msg_t)) writeback_queue (
        .clk(clk), .reset(reset), .push(wbq_push), .data_in(wbq_in),
        .pop(dram_wb_req_pop), .data_out(wbq_head), .empty(wbq_empty), .full(wbq_full)
    );

    bank_miss_resrv miss_resrv (
        .clk(clk), .reset(reset), .add(miss_add), .add_entry(st2_req),
        .fill_valid(fill_bcast), .fill_addr(st2_req.addr), .pop(mrvq_pop),
        .add_line_pending(line_pending), .head_ready(mrvq_head_ready),
        .head_entry(mrvq_head), .full(mrvq_full), .stop(mrvq_stop)
    );

    // Replays first, then fills, then core requests
    assign mrvq_pop  = mrvq_head_ready && !stall;
    assign fillq_pop = !fillq_empty && !mrvq_head_ready && !stall;
    assign reqq_pop  = !reqq_empty && !mrvq_head_ready && fillq_empty && !mrvq_stop &&
                       !st1_fill && !st2_fill && !stall;
    assign s0_valid  = mrvq_pop || fillq_pop || reqq_pop;

    always_comb begin
        if (mrvq_pop) begin
            s0_req = mrvq_head;
        end else if (fillq_pop) begin
            s0_req      = '0;
            s0_req.addr = fillq_head.addr;
        end else begin
            s0_req = reqq_head;
        end
    end

    bank_tag_data tag_data (
        .clk(clk), .reset(reset), .stall(stall), .read_addr(s0_req.addr),
        .access_valid(st1_valid), .access_fill(st1_fill), .access_write(st1_req.write),
        .access_addr(st1_req.addr), .write_word(st1_req.data), .fill_line(st1_line),
        .read_word(td_word), .read_line(td_line), .victim_tag(td_tag),
        .hit(td_hit), .victim_dirty(td_dirty)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            st1_valid <= 1'b0;
            st1_fill  <= 1'b0;
            st2_valid <= 1'b0;
            st2_fill  <= 1'b0;
        end else if (!stall) begin
            st1_valid <= s0_valid;
            st1_fill  <= fillq_pop;
            st2_valid <= st1_valid;
            st2_fill  <= st1_fill;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            st1_req   <= s0_req;
            st1_line  <= fillq_head.line;
            st2_req   <= st1_req;
            st2_word  <= td_word;
            st2_line  <= td_line;
            st2_tag   <= td_tag;
            st2_hit   <= td_hit;
            st2_dirty <= td_dirty;
        end
    end

    assign read_hit2  = st2_valid && !st2_fill && st2_hit && !st2_req.write;
    assign miss2      = st2_valid && !st2_fill && !st2_hit;
    assign need_fill2 = miss2 && !line_pending;
    assign victim2    = st2_valid && st2_fill && st2_dirty;

    assign stall = (read_hit2 && rspq_full) || (miss2 && mrvq_full) ||
                   (need_fill2 && dram_fill_req_full) || (victim2 && wbq_full);

    assign rspq_push = read_hit2 && !stall;
    assign rspq_in   = '{st2_req.tid, st2_word, st2_req.addr};
    assign miss_add  = miss2 && !stall;
    assign fill_bcast = st2_fill && !stall;
    assign wbq_push  = victim2 && !stall;
    assign wbq_in    = '{{st2_tag, st2_req.addr[`BANK_LINE_OFF_BITS +: `BANK_INDEX_BITS],
                          {`BANK_LINE_OFF_BITS{1'b0}}}, st2_line};

    assign dram_fill_req_valid = need_fill2 && !stall;
    assign dram_fill_req_addr  = {st2_req.addr[`BANK_ADDR_BITS-1:`BANK_LINE_OFF_BITS],
                                  {`BANK_LINE_OFF_BITS{1'b0}}};
    assign dram_fill_rsp_ready = !fillq_full;

    assign core_rsp_valid    = !rspq_empty;
    assign core_rsp_tid      = rspq_head.tid;
    assign core_rsp_data     = rspq_head.data;
    assign core_rsp_addr     = rspq_head.addr;
    assign dram_wb_req_valid = !wbq_empty;
    assign dram_wb_req_addr  = wbq_head.addr;
    assign dram_wb_req_data  = wbq_head.line;

    // A dirty victim is never the line being filled
    assert property (@(posedge clk) disable iff (reset)
        wbq_push |-> (st2_tag != st2_req.addr[`BANK_ADDR_BITS-1 -: `BANK_TAG_BITS]))
        else $error("cache_bank: fill overwrote its own dirty line");

endmodule

//--- rtl/bank_miss_resrv.sv
`timescale 1ns/1ns
`include "cache_bank_settings.svh"

module bank_miss_resrv (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        add,
    input  cache_bank_pkg::miss_entry_t add_entry,
    input  logic                        fill_valid,
    input  cache_bank_pkg::addr_t       fill_addr,
    input  logic                        pop,
    output logic                        add_line_pending,
    output logic                        head_ready,
    output cache_bank_pkg::miss_entry_t head_entry,
    output logic                        full,
    output logic                        stop
);
    import cache_bank_pkg::*;

    localparam int DEPTH     = `BANK_MRVQ_DEPTH;
    localparam int PTR_BITS  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS  = $clog2(DEPTH + 1);
    localparam int LINE_BITS = `BANK_ADDR_BITS - `BANK_LINE_OFF_BITS;

    miss_entry_t         entries [DEPTH];
    logic [DEPTH-1:0]    entry_valid;
    logic [DEPTH-1:0]    entry_ready;
    logic [PTR_BITS-1:0] head;
    logic [PTR_BITS-1:0] tail;
    logic [CNT_BITS-1:0] count;
    logic                any_ready;

    function automatic logic [LINE_BITS-1:0] line_of(input addr_t addr);
        return addr[`BANK_ADDR_BITS-1:`BANK_LINE_OFF_BITS];
    endfunction

    function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
        return (ptr == PTR_BITS'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // A waiting entry of the same line means its fill is already requested
    always_comb begin
        add_line_pending = 1'b0;
        for (int i = 0; i < DEPTH; i++) begin
            if (entry_valid[i] && !entry_ready[i] &&
                (line_of(entries[i].addr) == line_of(add_entry.addr)))
                add_line_pending = 1'b1;
        end
    end

    assign any_ready  = |(entry_valid & entry_ready);
    assign head_ready = entry_valid[head] && entry_ready[head];
    assign head_entry = entries[head];
    assign full       = (count == CNT_BITS'(DEPTH));
    // Keep room for the two staged requests and the one issuing;
    // woken entries behind the head also hold off new core traffic
    assign stop       = (count >= CNT_BITS'(DEPTH - 2)) || any_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            entry_valid <= '0;
            entry_ready <= '0;
            head        <= '0;
            tail        <= '0;
            count       <= '0;
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                if (fill_valid && entry_valid[i] &&
                    (line_of(entries[i].addr) == line_of(fill_addr)))
                    entry_ready[i] <= 1'b1;
            end
            if (pop) begin
                entry_valid[head] <= 1'b0;
                entry_ready[head] <= 1'b0;
                head              <= next_ptr(head);
            end
            if (add) begin
                entry_valid[tail] <= 1'b1;
                entry_ready[tail] <= 1'b0;
                tail              <= next_ptr(tail);
            end
            count <= count + CNT_BITS'(add) - CNT_BITS'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (add)
            entries[tail] <= add_entry;
    end

    assert property (@(posedge clk) disable iff (reset) add |-> !full)
        else $error("bank_miss_resrv: add while full");

endmodule

//--- rtl/bank_tag_data.sv
`timescale 1ns/1ns
`include "cache_bank_settings.svh"

module bank_tag_data (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      stall,
    input  cache_bank_pkg::addr_t     read_addr,
    input  logic                      access_valid,
    input  logic                      access_fill,
    input  logic                      access_write,
    input  cache_bank_pkg::addr_t     access_addr,
    input  cache_bank_pkg::word_t     write_word,
    input  cache_bank_pkg::line_t     fill_line,
    output cache_bank_pkg::word_t     read_word,
    output cache_bank_pkg::line_t     read_line,
    output logic [`BANK_TAG_BITS-1:0] victim_tag,
    output logic                      hit,
    output logic                      victim_dirty
);
    import cache_bank_pkg::*;

    typedef logic [`BANK_TAG_BITS-1:0]   tag_t;
    typedef logic [`BANK_INDEX_BITS-1:0] index_t;

    tag_t                       tag_mem [`BANK_NUM_LINES];
    line_t                      data_mem [`BANK_NUM_LINES];
    logic [`BANK_NUM_LINES-1:0] dirty_bits;
    logic [`BANK_NUM_LINES-1:0] valid_bits;

    // Indexed line as read at issue
    tag_t                       rd_tag;
    line_t                      rd_line;
    logic                       rd_valid;
    logic                       rd_dirty;

    index_t                     rd_index;
    index_t                     acc_index;
    tag_t                       acc_tag;
    logic [`BANK_WOFF_BITS-1:0] acc_woff;
    logic                       acc_store;
    line_t                      new_line;

    assign rd_index  = read_addr[`BANK_LINE_OFF_BITS +: `BANK_INDEX_BITS];
    assign acc_index = access_addr[`BANK_LINE_OFF_BITS +: `BANK_INDEX_BITS];
    assign acc_tag   = access_addr[`BANK_ADDR_BITS-1 -: `BANK_TAG_BITS];
    assign acc_woff  = access_addr[`BANK_BYTE_OFF_BITS +: `BANK_WOFF_BITS];

    assign hit       = access_valid && !access_fill && rd_valid && (rd_tag == acc_tag);
    // Write hit or fill changes the line
    assign acc_store = access_valid && (access_fill || (access_write && hit));

    always_comb begin
        new_line = rd_line;
        new_line[acc_woff] = write_word;
        if (access_fill)
            new_line = fill_line;
    end

    assign read_word    = rd_line[acc_woff];
    assign read_line    = rd_line;
    assign victim_tag   = rd_tag;
    assign victim_dirty = rd_valid && rd_dirty;

    // Forward the stage-1 update when the next access reads the same line
    always_ff @(posedge clk) begin
        if (!stall) begin
            if (acc_store && (rd_index == acc_index)) begin
                rd_tag   <= acc_tag;
                rd_line  <= new_line;
                rd_valid <= 1'b1;
                rd_dirty <= !access_fill;
            end else begin
                rd_tag   <= tag_mem[rd_index];
                rd_line  <= data_mem[rd_index];
                rd_valid <= valid_bits[rd_index];
                rd_dirty <= dirty_bits[rd_index];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (acc_store) begin
            tag_mem[acc_index]    <= acc_tag;
            data_mem[acc_index]   <= new_line;
            dirty_bits[acc_index] <= !access_fill;
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            valid_bits <= '0;
        else if (acc_store)
            valid_bits[acc_index] <= 1'b1;
    end

endmodule

//--- rtl/bank_queue.sv
`timescale 1ns/1ns

module bank_queue #(
    parameter int  DEPTH     = 4,
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     push,
    input  payload_t data_in,
    input  logic     pop,
    output payload_t data_out,
    output logic     empty,
    output logic     full
);

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    payload_t            slots [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic                do_push;
    logic                do_pop;

    function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
        return (ptr == PTR_BITS'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    assign empty    = (count == '0);
    assign full     = (count == CNT_BITS'(DEPTH));
    assign data_out = slots[rd_ptr];

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)
                rd_ptr <= next_ptr(rd_ptr);
            count <= count + CNT_BITS'(do_push) - CNT_BITS'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push)
            slots[wr_ptr] <= data_in;
    end

    // Producer and consumer must respect full and empty
    assert property (@(posedge clk) disable iff (reset) push |-> !full)
        else $error("bank_queue: push while full");
    assert property (@(posedge clk) disable iff (reset) pop |-> !empty)
        else $error("bank_queue: pop while empty");

endmodule

//--- rtl/cache_bank_pkg.sv
`include "cache_bank_settings.svh"

package cache_bank_pkg;

    typedef logic [`BANK_ADDR_BITS-1:0] addr_t;
    typedef logic [`BANK_WORD_BITS-1:0] word_t;
    typedef word_t [`BANK_LINE_WORDS-1:0] line_t;
    typedef logic [`BANK_TID_BITS-1:0] tid_t;

    typedef struct packed {
        logic  write;
        addr_t addr;
        word_t data;
        tid_t  tid;
    } core_req_t;

    typedef struct packed {
        tid_t  tid;
        word_t data;
        addr_t addr;
    } core_rsp_t;

    // Fill responses and writebacks
    typedef struct packed {
        addr_t addr;
        line_t line;
    } line_msg_t;

    // Parked misses replay as ordinary requests
    typedef core_req_t miss_entry_t;

endpackage

//--- rtl/cache_bank_settings.svh
`ifndef CACHE_BANK_SETTINGS_SVH
`define CACHE_BANK_SETTINGS_SVH

// Widths and geometry
`define BANK_ADDR_BITS      32
`define BANK_WORD_BITS      32
`define BANK_LINE_WORDS     4
`define BANK_NUM_LINES      16
`define BANK_TID_BITS       4

// Queue depths
`define BANK_REQQ_DEPTH     4
`define BANK_RSPQ_DEPTH     4
`define BANK_FILLQ_DEPTH    2
`define BANK_WBQ_DEPTH      2
`define BANK_MRVQ_DEPTH     4

// Address split: tag | index | word offset | byte offset
`define BANK_BYTE_OFF_BITS  $clog2(`BANK_WORD_BITS / 8)
`define BANK_WOFF_BITS      $clog2(`BANK_LINE_WORDS)
`define BANK_LINE_OFF_BITS  (`BANK_BYTE_OFF_BITS + `BANK_WOFF_BITS)
`define BANK_INDEX_BITS     $clog2(`BANK_NUM_LINES)
`define BANK_TAG_BITS       (`BANK_ADDR_BITS - `BANK_INDEX_BITS - `BANK_LINE_OFF_BITS)

`endif
